// ==== common/hex_loader_pkg.sv ====
package hex_loader_pkg;

	typedef logic [7:0] hl_byte_t;
	typedef logic [15:0] hl_addr_t;
	typedef logic [3:0] hl_nibble_t;

	typedef enum logic [2:0] {
		SYM_HEX,
		SYM_COLON,
		SYM_CR,
		SYM_LF,
		SYM_BAD
	} hl_sym_kind_e;

	typedef struct packed {
		hl_sym_kind_e kind;
		hl_nibble_t nib; // only meaningful for SYM_HEX
	} hl_sym_t;

	typedef enum logic [2:0] {
		ERR_OK,
		ERR_BAD_CHAR,
		ERR_ORDER,
		ERR_TYPE,
		ERR_CHECKSUM,
		ERR_TOO_LONG
	} hl_err_e;

	typedef struct packed {
		hl_addr_t addr;
		hl_byte_t data;
	} hl_data_t;

	typedef struct packed {
		hl_err_e err;
		hl_byte_t rtype;
		hl_byte_t count;
	} hl_rec_end_t;

	typedef hl_rec_end_t hl_rec_status_t; // outcome seen outside

endpackage

// ==== common/hex_loader_settings.svh ====
`ifndef HEX_LOADER_SETTINGS_SVH
`define HEX_LOADER_SETTINGS_SVH

`define HL_FIFO_DEPTH 8 // also the sender's starting credits

`define HL_MAX_REC_LEN 32 // largest data count per record

`define HL_MEM_AW 10 // low address bits kept by the load memory

`endif

// ==== hex_loader.f ====
+incdir+common
common/hex_loader_pkg.sv
src/char_fifo.sv
hex_parser/hex_record_parser.sv
hex_parser/record_checksum.sv
src/record_commit.sv
src/load_memory.sv
src/hex_loader_top.sv
tb/tb_hex_loader.sv

// ==== hex_parser/hex_record_parser.sv ====
`timescale 1ns/1ps
`include "hex_loader_settings.svh"

module hex_record_parser (
	input logic clk,
	input logic i_arst_n,
	input logic i_sym_valid,
	input hex_loader_pkg::hl_sym_t i_sym,
	input logic i_take,
	output logic o_data_valid,
	output hex_loader_pkg::hl_data_t o_data,
	output logic o_end_valid,
	output hex_loader_pkg::hl_rec_end_t o_rec_end
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_COUNT,
		ST_ADDR,
		ST_TYPE,
		ST_DATA,
		ST_CSUM,
		ST_CR,
		ST_LF,
		ST_SKIP
	} state_e;

	state_e state;
	logic [1:0] nib_left; // nibbles still due in the field, minus one
	logic [15:0] field;
	logic [15:0] field_nxt;
	hex_loader_pkg::hl_byte_t fbyte;
	hex_loader_pkg::hl_byte_t rec_count;
	hex_loader_pkg::hl_byte_t rec_type;
	hex_loader_pkg::hl_byte_t bytes_left;
	hex_loader_pkg::hl_byte_t data_seen;
	hex_loader_pkg::hl_addr_t rec_addr;
	hex_loader_pkg::hl_sym_kind_e exp_kind;
	hex_loader_pkg::hl_err_e sym_code;
	logic sym_err;
	logic take;
	logic last_nib;
	logic is_colon;

	assign take = i_sym_valid && i_take;
	assign field_nxt = {field[11:0], i_sym.nib};
	assign fbyte = field_nxt[7:0];
	assign last_nib = (nib_left == 2'd0);
	assign is_colon = (i_sym.kind == hex_loader_pkg::SYM_COLON);

	always_comb begin
		case (state)
			ST_IDLE: exp_kind = hex_loader_pkg::SYM_COLON;
			ST_CR: exp_kind = hex_loader_pkg::SYM_CR;
			ST_LF: exp_kind = hex_loader_pkg::SYM_LF;
			default: exp_kind = hex_loader_pkg::SYM_HEX;
		endcase
		sym_err = 1'b0;
		sym_code = hex_loader_pkg::ERR_ORDER;
		if (state != ST_SKIP) begin
			if (i_sym.kind == hex_loader_pkg::SYM_BAD) begin
				sym_err = 1'b1;
				sym_code = hex_loader_pkg::ERR_BAD_CHAR;
			end else if (i_sym.kind != exp_kind) begin
				sym_err = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			nib_left <= '0;
			field <= '0;
			rec_count <= '0;
			rec_type <= '0;
			rec_addr <= '0;
			bytes_left <= '0;
			data_seen <= '0;
			o_data_valid <= 1'b0;
			o_data <= '0;
			o_end_valid <= 1'b0;
			o_rec_end <= '0;
		end else begin
			o_data_valid <= 1'b0;
			o_end_valid <= 1'b0;
			if (o_data_valid)
				data_seen <= data_seen + 8'd1;
			if (take) begin
				if (sym_err) begin
					o_end_valid <= 1'b1;
					o_rec_end <= '{err: sym_code, rtype: rec_type, count: rec_count};
					rec_count <= '0;
					rec_type <= '0;
					state <= ST_SKIP;
				end
				if (is_colon && (sym_err || state == ST_IDLE || state == ST_SKIP)) begin
					state <= ST_COUNT; // a colon always opens a new record
					nib_left <= 2'd1;
					data_seen <= '0;
				end else if (!sym_err && i_sym.kind == hex_loader_pkg::SYM_HEX) begin
					field <= field_nxt;
					nib_left <= nib_left - 2'd1;
					case (state)
						ST_COUNT: if (last_nib) begin
							if (fbyte > 8'(`HL_MAX_REC_LEN)) begin
								o_end_valid <= 1'b1;
								o_rec_end <= '{err: hex_loader_pkg::ERR_TOO_LONG,
									rtype: 8'h00, count: fbyte};
								state <= ST_SKIP;
							end else begin
								rec_count <= fbyte;
								nib_left <= 2'd3;
								state <= ST_ADDR;
							end
						end
						ST_ADDR: if (last_nib) begin
							rec_addr <= field_nxt;
							nib_left <= 2'd1;
							state <= ST_TYPE;
						end
						ST_TYPE: if (last_nib) begin
							nib_left <= 2'd1;
							if (fbyte > 8'h01) begin // only 00 and 01 are applied
								o_end_valid <= 1'b1;
								o_rec_end <= '{err: hex_loader_pkg::ERR_TYPE,
									rtype: fbyte, count: rec_count};
								rec_count <= '0;
								state <= ST_SKIP;
							end else begin
								rec_type <= fbyte;
								bytes_left <= rec_count;
								state <= (rec_count == 8'd0) ? ST_CSUM : ST_DATA;
							end
						end
						ST_DATA: if (last_nib) begin
							if (rec_type == 8'h00) begin
								o_data_valid <= 1'b1;
								o_data <= '{addr: rec_addr, data: fbyte};
							end
							rec_addr <= rec_addr + 16'd1;
							bytes_left <= bytes_left - 8'd1;
							nib_left <= 2'd1;
							if (bytes_left == 8'd1)
								state <= ST_CSUM;
						end
						ST_CSUM: if (last_nib)
							state <= ST_CR; // sum itself is checked elsewhere
						default: ;
					endcase
				end else if (!sym_err) begin
					if (state == ST_CR)
						state <= ST_LF;
					else if (state == ST_LF) begin
						o_end_valid <= 1'b1;
						o_rec_end <= '{err: hex_loader_pkg::ERR_OK,
							rtype: rec_type, count: rec_count};
						rec_count <= '0;
						rec_type <= '0;
						state <= ST_IDLE;
					end
				end
			end
		end
	end

	// payload bytes of one record stay within its count
	a_data_in_count: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_data_valid |-> data_seen < rec_count)
		else $error("parser emitted more bytes than the count");

endmodule

// ==== hex_parser/record_checksum.sv ====
`timescale 1ns/1ps

module record_checksum (
	input logic clk,
	input logic i_arst_n,
	input logic i_sym_valid,
	input hex_loader_pkg::hl_sym_t i_sym,
	input logic i_take,
	output logic o_sum_valid,
	output logic o_sum_ok
);

	logic take;
	logic in_line; // a colon was seen, no LF yet
	logic have_hi;
	hex_loader_pkg::hl_nibble_t hi_nib;
	hex_loader_pkg::hl_byte_t sum;

	assign take = i_sym_valid && i_take;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			in_line <= 1'b0;
			have_hi <= 1'b0;
			hi_nib <= '0;
			sum <= '0;
			o_sum_valid <= 1'b0;
			o_sum_ok <= 1'b0;
		end else begin
			o_sum_valid <= 1'b0;
			if (take) begin
				case (i_sym.kind)
					hex_loader_pkg::SYM_COLON: begin
						sum <= '0;
						in_line <= 1'b1;
						have_hi <= 1'b0;
					end
					hex_loader_pkg::SYM_HEX: if (in_line) begin
						if (have_hi)
							sum <= sum + {hi_nib, i_sym.nib}; // wraps mod 256
						else
							hi_nib <= i_sym.nib;
						have_hi <= !have_hi;
					end
					hex_loader_pkg::SYM_LF: if (in_line) begin
						o_sum_valid <= 1'b1;
						o_sum_ok <= (sum == 8'h00);
						in_line <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f hex_loader.f \
	--top-module tb_hex_loader > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_hex_loader 2>&1 | tee sim.log

! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== src/char_fifo.sv ====
`timescale 1ns/1ps
`include "hex_loader_settings.svh"

module char_fifo (
	input logic clk,
	input logic i_arst_n,
	input logic i_char_valid,
	input hex_loader_pkg::hl_byte_t i_char,
	input logic i_pop,
	output logic o_sym_valid,
	output hex_loader_pkg::hl_sym_t o_sym,
	output logic o_credit
);

	localparam int DEPTH = `HL_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	hex_loader_pkg::hl_sym_t sym_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic pop;

	function automatic hex_loader_pkg::hl_sym_t classify(input hex_loader_pkg::hl_byte_t c);
		hex_loader_pkg::hl_sym_t s;
		s.kind = hex_loader_pkg::SYM_HEX;
		s.nib = '0;
		if (c >= 8'h30 && c <= 8'h39) // 0..9
			s.nib = c[3:0];
		else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66))
			s.nib = c[3:0] + 4'd9; // A..F and a..f share the low nibble
		else if (c == 8'h3a)
			s.kind = hex_loader_pkg::SYM_COLON;
		else if (c == 8'h0d)
			s.kind = hex_loader_pkg::SYM_CR;
		else if (c == 8'h0a)
			s.kind = hex_loader_pkg::SYM_LF;
		else
			s.kind = hex_loader_pkg::SYM_BAD;
		return s;
	endfunction

	assign o_sym_valid = (fill != '0);
	assign o_sym = sym_mem[rd_ptr];
	assign pop = i_pop && o_sym_valid;
	assign o_credit = pop; // one credit back per popped entry

	always_ff @(posedge clk) begin
		if (i_char_valid)
			sym_mem[wr_ptr] <= classify(i_char);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (i_char_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({i_char_valid, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// the sender holds no credit when the FIFO is full
	a_no_overrun: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_char_valid |-> fill != CNT_W'(DEPTH))
		else $error("char_fifo push while full");

endmodule

// ==== src/hex_loader_top.sv ====
`timescale 1ns/1ps

module hex_loader_top (
	input logic clk,
	input logic i_arst_n,
	input logic i_char_valid,
	input hex_loader_pkg::hl_byte_t i_char,
	input hex_loader_pkg::hl_addr_t i_rd_addr,
	output logic o_credit,
	output logic o_rec_valid,
	output hex_loader_pkg::hl_rec_status_t o_rec_status,
	output logic o_eof,
	output hex_loader_pkg::hl_byte_t o_rd_data
);

	logic sym_valid;
	hex_loader_pkg::hl_sym_t sym;
	logic commit_ready; // gates the pop and both consumers
	logic data_valid;
	hex_loader_pkg::hl_data_t data;
	logic end_valid;
	hex_loader_pkg::hl_rec_end_t rec_end;
	logic sum_valid;
	logic sum_ok;
	logic wr_en;
	hex_loader_pkg::hl_addr_t wr_addr;
	hex_loader_pkg::hl_byte_t wr_data;

	char_fifo u_char_fifo (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_char_valid(i_char_valid),
		.i_char(i_char),
		.i_pop(commit_ready),
		.o_sym_valid(sym_valid),
		.o_sym(sym),
		.o_credit(o_credit)
	);

	hex_record_parser u_parser (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_sym_valid(sym_valid),
		.i_sym(sym),
		.i_take(commit_ready),
		.o_data_valid(data_valid),
		.o_data(data),
		.o_end_valid(end_valid),
		.o_rec_end(rec_end)
	);

	record_checksum u_checksum (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_sym_valid(sym_valid),
		.i_sym(sym),
		.i_take(commit_ready),
		.o_sum_valid(sum_valid),
		.o_sum_ok(sum_ok)
	);

	record_commit u_commit (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_data_valid(data_valid),
		.i_data(data),
		.i_end_valid(end_valid),
		.i_rec_end(rec_end),
		.i_sum_valid(sum_valid),
		.i_sum_ok(sum_ok),
		.o_ready(commit_ready),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data),
		.o_rec_valid(o_rec_valid),
		.o_rec_status(o_rec_status),
		.o_eof(o_eof)
	);

	load_memory u_memory (
		.clk(clk),
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.i_rd_addr(i_rd_addr),
		.o_rd_data(o_rd_data)
	);

endmodule

// ==== src/load_memory.sv ====
`timescale 1ns/1ps
`include "hex_loader_settings.svh"

module load_memory (
	input logic clk,
	input logic i_wr_en,
	input hex_loader_pkg::hl_addr_t i_wr_addr,
	input hex_loader_pkg::hl_byte_t i_wr_data,
	input hex_loader_pkg::hl_addr_t i_rd_addr,
	output hex_loader_pkg::hl_byte_t o_rd_data
);

	localparam int AW = `HL_MEM_AW;

	hex_loader_pkg::hl_byte_t mem [2**AW];

	// upper record address bits are dropped
	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr[AW-1:0]] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr[AW-1:0]]; // one cycle read latency
	end

endmodule

// ==== src/record_commit.sv ====
`timescale 1ns/1ps
`include "hex_loader_settings.svh"

module record_commit (
	input logic clk,
	input logic i_arst_n,
	input logic i_data_valid,
	input hex_loader_pkg::hl_data_t i_data,
	input logic i_end_valid,
	input hex_loader_pkg::hl_rec_end_t i_rec_end,
	input logic i_sum_valid,
	input logic i_sum_ok,
	output logic o_ready,
	output logic o_wr_en,
	output hex_loader_pkg::hl_addr_t o_wr_addr,
	output hex_loader_pkg::hl_byte_t o_wr_data,
	output logic o_rec_valid,
	output hex_loader_pkg::hl_rec_status_t o_rec_status,
	output logic o_eof
);

	localparam int MAX_LEN = `HL_MAX_REC_LEN;
	localparam int IDX_W = $clog2(MAX_LEN);
	localparam int CNT_W = $clog2(MAX_LEN + 1);

	typedef enum logic {
		CM_COLLECT,
		CM_DRAIN
	} state_e;

	state_e state;
	hex_loader_pkg::hl_data_t rec_buf [MAX_LEN];
	logic [CNT_W-1:0] buf_cnt;
	logic [IDX_W-1:0] rd_idx;
	hex_loader_pkg::hl_rec_end_t pend;
	hex_loader_pkg::hl_rec_status_t end_status;
	logic rec_good;
	logic buf_push;
	logic last_wr;

	assign rec_good = (i_rec_end.err == hex_loader_pkg::ERR_OK) && i_sum_valid && i_sum_ok;
	assign buf_push = i_data_valid && (buf_cnt < CNT_W'(MAX_LEN));
	assign last_wr = (CNT_W'(rd_idx) + CNT_W'(1)) == buf_cnt;

	assign o_ready = (state == CM_COLLECT) && !i_end_valid;
	assign o_wr_en = (state == CM_DRAIN);
	assign o_wr_addr = rec_buf[rd_idx].addr;
	assign o_wr_data = rec_buf[rd_idx].data;

	always_comb begin
		end_status = i_rec_end;
		if (i_rec_end.err == hex_loader_pkg::ERR_OK && !rec_good)
			end_status.err = hex_loader_pkg::ERR_CHECKSUM;
	end

	always_ff @(posedge clk) begin
		if (buf_push)
			rec_buf[buf_cnt[IDX_W-1:0]] <= i_data;
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= CM_COLLECT;
			buf_cnt <= '0;
			rd_idx <= '0;
			pend <= '0;
			o_rec_valid <= 1'b0;
			o_rec_status <= '0;
			o_eof <= 1'b0;
		end else begin
			o_rec_valid <= 1'b0;
			o_eof <= 1'b0;
			case (state)
				CM_COLLECT: begin
					if (buf_push)
						buf_cnt <= buf_cnt + 1'b1;
					if (i_end_valid) begin
						if (rec_good && buf_cnt != '0) begin
							pend <= i_rec_end;
							rd_idx <= '0;
							state <= CM_DRAIN;
						end else begin
							o_rec_valid <= 1'b1; // error, bad sum or empty record
							o_rec_status <= end_status;
							o_eof <= rec_good && (i_rec_end.rtype == 8'h01);
							buf_cnt <= '0;
						end
					end
				end
				CM_DRAIN: begin
					rd_idx <= rd_idx + 1'b1;
					if (last_wr) begin
						o_rec_valid <= 1'b1;
						o_rec_status <= pend;
						buf_cnt <= '0;
						state <= CM_COLLECT;
					end
				end
				default: state <= CM_COLLECT;
			endcase
		end
	end

	// parser and checksum unit close a clean line in the same cycle
	a_end_with_sum: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_end_valid && i_rec_end.err == hex_loader_pkg::ERR_OK |-> i_sum_valid)
		else $error("clean record end without checksum result");

endmodule

// ==== tb/tb_hex_loader.sv ====
`timescale 1ns/1ps
`include "hex_loader_settings.svh"

module tb_hex_loader;

	localparam int MEM_SIZE = 1 << `HL_MEM_AW;

	typedef enum {C_NONE, C_CSUM, C_BAD_CHAR, C_NO_COLON, C_NO_CR, C_NO_LF} corrupt_e;

	logic clk;
	logic i_arst_n;
	logic i_char_valid;
	hex_loader_pkg::hl_byte_t i_char;
	hex_loader_pkg::hl_addr_t i_rd_addr;
	logic o_credit;
	logic o_rec_valid;
	hex_loader_pkg::hl_rec_status_t o_rec_status;
	logic o_eof;
	hex_loader_pkg::hl_byte_t o_rd_data;

	hex_loader_pkg::hl_byte_t char_q[$]; // whole input text
	hex_loader_pkg::hl_rec_status_t exp_q[$];
	logic eof_q[$];
	hex_loader_pkg::hl_byte_t shadow [MEM_SIZE];
	bit written [MEM_SIZE];
	hex_loader_pkg::hl_addr_t last_good_addr = '0;
	int credits_used = 0;
	int credits_back = 0;
	int cycles = 0;
	int cycle_limit = 100000;

	hex_loader_top uut (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_char_valid(i_char_valid),
		.i_char(i_char),
		.i_rd_addr(i_rd_addr),
		.o_credit(o_credit),
		.o_rec_valid(o_rec_valid),
		.o_rec_status(o_rec_status),
		.o_eof(o_eof),
		.o_rd_data(o_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// expected outcome of one record, shadow memory follows accepted data
	function automatic hex_loader_pkg::hl_rec_status_t hex_model(
		input hex_loader_pkg::hl_byte_t count,
		input hex_loader_pkg::hl_addr_t addr,
		input hex_loader_pkg::hl_byte_t rtype,
		input hex_loader_pkg::hl_byte_t payload[$],
		input corrupt_e corrupt
	);
		hex_loader_pkg::hl_rec_status_t st;
		hex_loader_pkg::hl_addr_t wa;
		st.err = hex_loader_pkg::ERR_OK;
		st.rtype = rtype;
		st.count = count;
		if (corrupt == C_NO_COLON) begin
			st.err = hex_loader_pkg::ERR_ORDER; // no field parsed yet
			st.rtype = 8'h00;
			st.count = 8'h00;
		end else if (count > 8'(`HL_MAX_REC_LEN)) begin
			st.err = hex_loader_pkg::ERR_TOO_LONG;
			st.rtype = 8'h00; // type field never reached
		end else if (rtype > 8'h01)
			st.err = hex_loader_pkg::ERR_TYPE;
		else if (corrupt == C_BAD_CHAR)
			st.err = hex_loader_pkg::ERR_BAD_CHAR;
		else if (corrupt == C_NO_CR || corrupt == C_NO_LF)
			st.err = hex_loader_pkg::ERR_ORDER;
		else if (corrupt == C_CSUM)
			st.err = hex_loader_pkg::ERR_CHECKSUM;
		if (st.err == hex_loader_pkg::ERR_OK && rtype == 8'h00) begin
			for (int i = 0; i < int'(count); i++) begin
				wa = addr + 16'(i);
				shadow[wa[`HL_MEM_AW-1:0]] = payload[i];
				written[wa[`HL_MEM_AW-1:0]] = 1'b1;
			end
		end
		return st;
	endfunction

	function automatic hex_loader_pkg::hl_byte_t hex_digit(input hex_loader_pkg::hl_nibble_t nib);
		logic lower;
		lower = 1'($urandom % 2); // mixed case digits
		if (nib < 4'd10)
			return 8'h30 + 8'(nib);
		return (lower ? 8'h61 : 8'h41) + 8'(nib) - 8'd10;
	endfunction

	task automatic push_hex_byte(input hex_loader_pkg::hl_byte_t b);
		char_q.push_back(hex_digit(b[7:4]));
		char_q.push_back(hex_digit(b[3:0]));
	endtask

	task automatic emit_record_text(
		input hex_loader_pkg::hl_byte_t count,
		input hex_loader_pkg::hl_addr_t addr,
		input hex_loader_pkg::hl_byte_t rtype,
		input hex_loader_pkg::hl_byte_t payload[$],
		input corrupt_e corrupt
	);
		hex_loader_pkg::hl_byte_t sum;
		sum = count + addr[15:8] + addr[7:0] + rtype;
		foreach (payload[i])
			sum = sum + payload[i];
		sum = 8'h00 - sum; // line adds up to zero
		if (corrupt == C_CSUM)
			sum = sum + 8'h01;
		if (corrupt != C_NO_COLON)
			char_q.push_back(8'h3a);
		push_hex_byte(count);
		push_hex_byte(addr[15:8]);
		push_hex_byte(addr[7:0]);
		push_hex_byte(rtype);
		foreach (payload[i]) begin
			if (i == 0 && corrupt == C_BAD_CHAR) begin
				char_q.push_back(8'h47); // 'G' in place of a digit
				char_q.push_back(hex_digit(payload[0][3:0]));
			end else
				push_hex_byte(payload[i]);
		end
		push_hex_byte(sum);
		if (corrupt != C_NO_CR)
			char_q.push_back(8'h0d);
		if (corrupt != C_NO_LF)
			char_q.push_back(8'h0a);
	endtask

	task automatic add_record(
		input hex_loader_pkg::hl_byte_t count,
		input hex_loader_pkg::hl_addr_t addr,
		input hex_loader_pkg::hl_byte_t rtype,
		input corrupt_e corrupt
	);
		hex_loader_pkg::hl_byte_t payload[$];
		hex_loader_pkg::hl_rec_status_t st;
		for (int i = 0; i < int'(count); i++)
			payload.push_back(8'($urandom));
		st = hex_model(count, addr, rtype, payload, corrupt);
		exp_q.push_back(st);
		eof_q.push_back(st.err == hex_loader_pkg::ERR_OK && st.rtype == 8'h01);
		if (st.err == hex_loader_pkg::ERR_OK && rtype == 8'h00 && count != 8'h00)
			last_good_addr = addr; // rejected records aim here later
		emit_record_text(count, addr, rtype, payload, corrupt);
	endtask

	task automatic add_random_data_record();
		add_record(8'(1 + $urandom % 16), hex_loader_pkg::hl_addr_t'($urandom), 8'h00, C_NONE);
	endtask

	task automatic build_all_records();
		for (int i = 0; i < 12; i++)
			add_random_data_record();
		add_record(8'h00, last_good_addr, 8'h00, C_NONE); // empty data record
		add_record(8'h06, last_good_addr, 8'h00, C_CSUM);
		add_random_data_record();
		add_record(8'h05, last_good_addr, 8'h00, C_BAD_CHAR);
		add_random_data_record();
		add_record(8'h04, last_good_addr, 8'h00, C_NO_COLON);
		add_random_data_record();
		add_record(8'h03, last_good_addr, 8'h00, C_NO_CR);
		add_random_data_record();
		add_record(8'h03, last_good_addr, 8'h00, C_NO_LF);
		add_random_data_record();
		add_record(8'h02, last_good_addr, 8'h02, C_NONE);
		add_record(8'h04, last_good_addr, 8'h04, C_NONE);
		add_record(8'(`HL_MAX_REC_LEN), hex_loader_pkg::hl_addr_t'($urandom), 8'h00, C_NONE);
		add_record(8'(`HL_MAX_REC_LEN + 1), last_good_addr, 8'h00, C_NONE);
		add_random_data_record();
		add_record(8'h00, 16'h0000, 8'h01, C_NONE); // end of file
		add_random_data_record();
		add_random_data_record();
	endtask

	task automatic send_char(input hex_loader_pkg::hl_byte_t c);
		int gap;
		gap = ($urandom % 4 == 0) ? 1 + int'($urandom % 3) : 0;
		repeat (gap) begin
			@(posedge clk);
			i_char_valid <= 1'b0;
		end
		@(posedge clk);
		while (`HL_FIFO_DEPTH + credits_back - credits_used <= 0) begin
			i_char_valid <= 1'b0; // out of credits
			@(posedge clk);
		end
		i_char_valid <= 1'b1;
		i_char <= c;
		credits_used = credits_used + 1;
	endtask

	task automatic readback_memory();
		for (int a = 0; a < MEM_SIZE; a++) begin
			if (written[a]) begin
				@(posedge clk);
				i_rd_addr <= hex_loader_pkg::hl_addr_t'(a);
				@(posedge clk);
				@(negedge clk);
				check_equal(32'(o_rd_data), 32'(shadow[a]), "memory readback");
			end
		end
	endtask

	initial begin : watchdog
		forever begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles > cycle_limit) begin
				$display("Simulation hung: still running after %0d cycles", cycles);
				abort_run();
			end
		end
	end

	// outputs are sampled at the falling edge
	initial begin : status_checker
		hex_loader_pkg::hl_rec_status_t exp_st;
		logic exp_eof;
		forever begin
			@(negedge clk);
			if (o_credit)
				credits_back = credits_back + 1;
			if (o_rec_valid && exp_q.size() == 0) begin
				$display("Record status %h reported with none expected", o_rec_status);
				abort_run();
			end else if (o_rec_valid) begin
				exp_st = exp_q.pop_front();
				exp_eof = eof_q.pop_front();
				check_equal(32'(o_rec_status), 32'(exp_st), "record status");
				check_equal(32'(o_eof), 32'(exp_eof), "eof flag");
			end else
				check_equal(32'(o_eof), 32'(0), "eof without record status");
		end
	end

	initial begin : main_flow
		void'($urandom(32'h2cfd));
		i_arst_n = 1'b0;
		i_char_valid = 1'b0;
		i_char = '0;
		i_rd_addr = '0;
		build_all_records();
		cycle_limit = char_q.size() * 4 + 4000 + 3 * MEM_SIZE;
		repeat (16) @(posedge clk);
		i_arst_n <= 1'b1;
		@(posedge clk);
		foreach (char_q[i])
			send_char(char_q[i]);
		@(posedge clk);
		i_char_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		check_equal(32'(credits_back), 32'(credits_used), "credits returned");
		readback_memory();
		$display("RESULT: PASS");
		$finish;
	end

endmodule
